//--- Makefile
VERILATOR  = verilator
FILELIST   = files.f
TOP        = tb_rob
RTL_TOP    = rob_top
OBJ_DIR    = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
FAIL_MSG   = Checks failed
PASS_MSG   = All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/instr_pkg.sv
`default_nettype none

package instr_pkg;

   // Program counter width
   localparam int XLEN = 32;

   typedef enum logic [2:0] {
      OP_ALU,
      OP_LOAD,
      OP_STORE,
      OP_BRANCH,
      OP_JUMP
   } t_opcode;

   // Architectural register index
   typedef logic [4:0] t_arch_reg;

endpackage

`default_nettype wire

//--- design/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc #(
   parameter int ROB_DEPTH = 8
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  alloc_valid,
   input  logic                  retire,
   input  logic                  flush_now,
   output logic [ROB_DEPTH-1:0]  alloc_oh,
   output rob_defs_pkg::t_rob_id alloc_robid,
   output logic                  full
);

   localparam int CNT_W = $clog2(ROB_DEPTH + 1);

   rob_defs_pkg::t_rob_id tail;
   logic [CNT_W-1:0]      count;
   logic                  accept;

   assign full        = (count == CNT_W'(ROB_DEPTH));
   assign alloc_robid = tail;

   // Dropped while full or in the flush cycle
   assign accept = alloc_valid && !full && !flush_now;

   always_comb begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
         alloc_oh[i] = accept && (int'(tail.idx) == i);
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush_now) begin
         tail  <= '0;
         count <= '0;
      end else begin
         if (accept) begin
            tail <= rob_defs_pkg::next_id(tail, ROB_DEPTH);
         end
         case ({accept, retire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_count_max: assert property (@(posedge clk) disable iff (reset)
      count <= CNT_W'(ROB_DEPTH));

endmodule

`default_nettype wire

//--- design/rob_defs_pkg.sv
`default_nettype none

package rob_defs_pkg;

   // Up to 8 entries
   localparam int ROB_ID_W = 3;

   // Generation toggles on every pointer wrap
   typedef struct packed {
      logic                gen;
      logic [ROB_ID_W-1:0] idx;
   } t_rob_id;

   typedef struct packed {
      instr_pkg::t_opcode          opcode;
      instr_pkg::t_arch_reg        dest;
      logic [instr_pkg::XLEN-1:0]  pc;
   } t_rob_ent_static;

   typedef struct packed {
      logic                        ready;
      logic                        flush_needed;
      logic [instr_pkg::XLEN-1:0]  redirect_pc;
   } t_rob_ent_dyn;

   typedef struct packed {
      t_rob_ent_static s;
      t_rob_ent_dyn    d;
   } t_rob_ent;

   typedef struct packed {
      t_rob_id                     robid;
      logic                        mispred;
      logic [instr_pkg::XLEN-1:0]  redirect_pc;
   } t_rob_result;

   // Pointer increment with wrap at depth
   function automatic t_rob_id next_id(t_rob_id id, int unsigned depth);
      t_rob_id nxt;
      nxt = id;
      if (int'(id.idx) == int'(depth) - 1) begin
         nxt.idx = '0;
         nxt.gen = ~id.gen;
      end else begin
         nxt.idx = id.idx + 1'b1;
      end
      return nxt;
   endfunction

endpackage

`default_nettype wire

//--- design/rob_entry.sv
`timescale 1ns/1ps
`default_nettype none

module rob_entry (
   input  logic                          clk,
   input  logic                          reset,
   input  rob_defs_pkg::t_rob_id         idx,
   input  rob_defs_pkg::t_rob_ent_static alloc_s,
   input  logic                          alloc,
   rob_wb_if.entry                       wb,
   input  logic                          flush_now,
   input  logic                          retire,
   output logic                          valid,
   output rob_defs_pkg::t_rob_ent        entry
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_PEND,
      ST_READY,
      ST_FLUSH
   } t_ent_state;

   t_ent_state                    state;
   t_ent_state                    state_nxt;
   rob_defs_pkg::t_rob_result     res;
   logic                          wb_hit;
   logic                          mispred_hit;
   rob_defs_pkg::t_rob_ent_static s_q;
   logic [instr_pkg::XLEN-1:0]    redirect_q;

   assign res = '{robid: wb.robid, mispred: wb.mispred, redirect_pc: wb.redirect_pc};

   // Index compare only, a live id is unique within the buffer
   assign wb_hit      = wb.valid && (res.robid.idx == idx.idx);
   assign mispred_hit = wb_hit && res.mispred && (state == ST_PEND);

   always_comb begin
      state_nxt = state;
      unique case (state)
         ST_IDLE: begin
            if (alloc) state_nxt = ST_PEND;
         end
         ST_PEND: begin
            if (flush_now) state_nxt = ST_IDLE;
            else if (mispred_hit) state_nxt = ST_FLUSH;
            else if (wb_hit) state_nxt = ST_READY;
         end
         ST_READY: begin
            if (flush_now || retire) state_nxt = ST_IDLE;
         end
         ST_FLUSH: begin
            if (flush_now) state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Static fields and redirect target
   always_ff @(posedge clk) begin
      if (alloc) begin
         s_q <= alloc_s;
      end
      if (mispred_hit) begin
         redirect_q <= res.redirect_pc;
      end
   end

   assign valid = (state != ST_IDLE);
   assign entry = '{s: s_q,
                    d: '{ready:        (state == ST_READY),
                         flush_needed: (state == ST_FLUSH),
                         redirect_pc:  redirect_q}};

   a_wb_live: assert property (@(posedge clk) disable iff (reset)
      wb_hit |-> state != ST_IDLE);

   // Allocator must never hand out a live slot
   a_alloc_free: assert property (@(posedge clk) disable iff (reset)
      alloc |-> state == ST_IDLE);

endmodule

`default_nettype wire

//--- design/rob_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rob_retire #(
   parameter int ROB_DEPTH = 8
) (
   input  logic                        clk,
   input  logic                        reset,
   input  rob_defs_pkg::t_rob_ent      entries [ROB_DEPTH],
   input  logic [ROB_DEPTH-1:0]        valids,
   output logic [ROB_DEPTH-1:0]        retire_oh,
   output logic                        retire,
   output logic                        flush_now,
   output logic                        retire_valid,
   output rob_defs_pkg::t_rob_id       retire_robid,
   output instr_pkg::t_opcode          retire_opcode,
   output instr_pkg::t_arch_reg        retire_dest,
   output logic [instr_pkg::XLEN-1:0]  retire_pc,
   output logic                        flush_valid,
   output rob_defs_pkg::t_rob_id       flush_robid,
   output logic [instr_pkg::XLEN-1:0]  flush_pc
);

   rob_defs_pkg::t_rob_id  head;
   rob_defs_pkg::t_rob_ent head_ent;
   logic                   head_valid;

   // Oldest entry
   assign head_ent   = entries[head.idx];
   assign head_valid = valids[head.idx];

   assign retire    = head_valid && head_ent.d.ready;
   assign flush_now = head_valid && head_ent.d.flush_needed;

   always_comb begin
      for (int i = 0; i < ROB_DEPTH; i++) begin
         retire_oh[i] = retire && (int'(head.idx) == i);
      end
   end

   assign retire_valid  = retire;
   assign retire_robid  = head;
   assign retire_opcode = head_ent.s.opcode;
   assign retire_dest   = head_ent.s.dest;
   assign retire_pc     = head_ent.s.pc;

   // Whole buffer goes, including the mispredicting head
   assign flush_valid = flush_now;
   assign flush_robid = head;
   assign flush_pc    = head_ent.d.redirect_pc;

   always_ff @(posedge clk) begin
      if (reset || flush_now) begin
         head <= '0;
      end else if (retire) begin
         head <= rob_defs_pkg::next_id(head, ROB_DEPTH);
      end
   end

   // Ready and flush-needed are exclusive states of one entry
   a_no_retire_flush: assert property (@(posedge clk) disable iff (reset)
      !(retire && flush_now));

endmodule

`default_nettype wire

//--- design/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_top #(
   parameter int ROB_DEPTH = 8
) (
   input  logic                        clk,
   input  logic                        reset,

   input  logic                        alloc_valid,
   input  instr_pkg::t_opcode          alloc_opcode,
   input  instr_pkg::t_arch_reg        alloc_dest,
   input  logic [instr_pkg::XLEN-1:0]  alloc_pc,

   input  logic                        wb_valid,
   input  rob_defs_pkg::t_rob_id       wb_robid,
   input  logic                        wb_mispred,
   input  logic [instr_pkg::XLEN-1:0]  wb_redirect_pc,

   output rob_defs_pkg::t_rob_id       alloc_robid,
   output logic                        full,

   output logic                        retire_valid,
   output rob_defs_pkg::t_rob_id       retire_robid,
   output instr_pkg::t_opcode          retire_opcode,
   output instr_pkg::t_arch_reg        retire_dest,
   output logic [instr_pkg::XLEN-1:0]  retire_pc,

   output logic                        flush_valid,
   output rob_defs_pkg::t_rob_id       flush_robid,
   output logic [instr_pkg::XLEN-1:0]  flush_pc
);

   rob_defs_pkg::t_rob_ent_static alloc_s;
   logic [ROB_DEPTH-1:0]          alloc_oh;
   logic [ROB_DEPTH-1:0]          retire_oh;
   logic [ROB_DEPTH-1:0]          valids;
   rob_defs_pkg::t_rob_ent        entries [ROB_DEPTH];
   logic                          retire;
   logic                          flush_now;

   rob_wb_if wb_bus ();

   // Execution side of the broadcast
   assign wb_bus.valid       = wb_valid;
   assign wb_bus.robid       = wb_robid;
   assign wb_bus.mispred     = wb_mispred;
   assign wb_bus.redirect_pc = wb_redirect_pc;

   assign alloc_s = '{opcode: alloc_opcode, dest: alloc_dest, pc: alloc_pc};

   rob_alloc #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_alloc (
      .clk         (clk),
      .reset       (reset),
      .alloc_valid (alloc_valid),
      .retire      (retire),
      .flush_now   (flush_now),
      .alloc_oh    (alloc_oh),
      .alloc_robid (alloc_robid),
      .full        (full)
   );

   for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entry
      rob_entry u_entry (
         .clk       (clk),
         .reset     (reset),
         .idx       (rob_defs_pkg::t_rob_id'(i)),
         .alloc_s   (alloc_s),
         .alloc     (alloc_oh[i]),
         .wb        (wb_bus),
         .flush_now (flush_now),
         .retire    (retire_oh[i]),
         .valid     (valids[i]),
         .entry     (entries[i])
      );
   end

   rob_retire #(
      .ROB_DEPTH (ROB_DEPTH)
   ) u_retire (
      .clk           (clk),
      .reset         (reset),
      .entries       (entries),
      .valids        (valids),
      .retire_oh     (retire_oh),
      .retire        (retire),
      .flush_now     (flush_now),
      .retire_valid  (retire_valid),
      .retire_robid  (retire_robid),
      .retire_opcode (retire_opcode),
      .retire_dest   (retire_dest),
      .retire_pc     (retire_pc),
      .flush_valid   (flush_valid),
      .flush_robid   (flush_robid),
      .flush_pc      (flush_pc)
   );

endmodule

`default_nettype wire

//--- design/rob_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

// One-cycle writeback broadcast, no back-pressure
interface rob_wb_if;

   logic                        valid;
   rob_defs_pkg::t_rob_id       robid;
   logic                        mispred;
   logic [instr_pkg::XLEN-1:0]  redirect_pc;

   modport exec (
      output valid,
      output robid,
      output mispred,
      output redirect_pc
   );

   modport entry (
      input valid,
      input robid,
      input mispred,
      input redirect_pc
   );

endinterface

`default_nettype wire

//--- files.f
design/instr_pkg.sv
design/rob_defs_pkg.sv
design/rob_wb_if.sv
design/rob_entry.sv
design/rob_alloc.sv
design/rob_retire.sv
design/rob_top.sv
test/tb_clock.sv
test/tb_rob.sv

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS = 40
) (
   output logic clk
);

   // Free running, starts low
   initial begin
      clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk = ~clk;
      end
   end

endmodule

`default_nettype wire

//--- test/tb_rob.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

   localparam int DEPTH   = 8;
   localparam int TIMEOUT = 200;

   typedef struct {
      rob_defs_pkg::t_rob_id      robid;
      instr_pkg::t_opcode         opcode;
      instr_pkg::t_arch_reg       dest;
      logic [instr_pkg::XLEN-1:0] pc;
   } t_instr;

   // Expected retire or flush record
   typedef struct {
      logic                       is_flush;
      rob_defs_pkg::t_rob_id      robid;
      instr_pkg::t_opcode         opcode;
      instr_pkg::t_arch_reg       dest;
      logic [instr_pkg::XLEN-1:0] pc;
   } t_record;

   logic                       clk;
   logic                       reset;
   logic                       alloc_valid;
   instr_pkg::t_opcode         alloc_opcode;
   instr_pkg::t_arch_reg       alloc_dest;
   logic [instr_pkg::XLEN-1:0] alloc_pc;
   logic                       wb_valid;
   rob_defs_pkg::t_rob_id      wb_robid;
   logic                       wb_mispred;
   logic [instr_pkg::XLEN-1:0] wb_redirect_pc;
   rob_defs_pkg::t_rob_id      alloc_robid;
   logic                       full;
   logic                       retire_valid;
   rob_defs_pkg::t_rob_id      retire_robid;
   instr_pkg::t_opcode         retire_opcode;
   instr_pkg::t_arch_reg       retire_dest;
   logic [instr_pkg::XLEN-1:0] retire_pc;
   logic                       flush_valid;
   rob_defs_pkg::t_rob_id      flush_robid;
   logic [instr_pkg::XLEN-1:0] flush_pc;

   // Reference model state
   t_instr                     alloc_q [$];
   int unsigned                alloc_seq;
   logic                       wb_done [DEPTH];
   logic                       wb_mis [DEPTH];
   logic [instr_pkg::XLEN-1:0] wb_redir [DEPTH];
   int                         retire_count;
   int                         flush_count;

   int seed;
   int checks;
   int errors;
   int tests_run;
   int tests_failed;
   int test_errors_base;

   tb_clock #(.PERIOD_NS(40)) u_clock (.clk(clk));

   rob_top #(.ROB_DEPTH(DEPTH)) i_dut (
      .clk            (clk),
      .reset          (reset),
      .alloc_valid    (alloc_valid),
      .alloc_opcode   (alloc_opcode),
      .alloc_dest     (alloc_dest),
      .alloc_pc       (alloc_pc),
      .wb_valid       (wb_valid),
      .wb_robid       (wb_robid),
      .wb_mispred     (wb_mispred),
      .wb_redirect_pc (wb_redirect_pc),
      .alloc_robid    (alloc_robid),
      .full           (full),
      .retire_valid   (retire_valid),
      .retire_robid   (retire_robid),
      .retire_opcode  (retire_opcode),
      .retire_dest    (retire_dest),
      .retire_pc      (retire_pc),
      .flush_valid    (flush_valid),
      .flush_robid    (flush_robid),
      .flush_pc       (flush_pc)
   );

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("FAIL %s expected %0h actual %0h at %0t", name, expected, actual, $time);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("ERROR %s at %0t", msg, $time);
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // n-th allocation since reset or flush, generation flips every DEPTH
   function automatic rob_defs_pkg::t_rob_id id_of_count(input int unsigned n);
      rob_defs_pkg::t_rob_id id;
      id.idx = rob_defs_pkg::ROB_ID_W'(n % DEPTH);
      id.gen = 1'((n / DEPTH) % 2);
      return id;
   endfunction

   // Head retires unless its writeback mispredicted
   function automatic t_record expected_record(input t_instr ins);
      t_record r;
      r.is_flush = wb_mis[ins.robid.idx];
      r.robid    = ins.robid;
      r.opcode   = ins.opcode;
      r.dest     = ins.dest;
      r.pc       = r.is_flush ? wb_redir[ins.robid.idx] : ins.pc;
      return r;
   endfunction

   function automatic void clear_wb();
      for (int i = 0; i < DEPTH; i++) begin
         wb_done[i]  = 1'b0;
         wb_mis[i]   = 1'b0;
         wb_redir[i] = '0;
      end
   endfunction

   task automatic tick();
      @(posedge clk);
      #2;
      alloc_valid = 1'b0;
      wb_valid    = 1'b0;
      wb_mispred  = 1'b0;
   endtask

   task automatic drive_alloc(input instr_pkg::t_opcode op, input instr_pkg::t_arch_reg dest,
                              input logic [instr_pkg::XLEN-1:0] pc,
                              output rob_defs_pkg::t_rob_id id);
      t_instr ins;
      logic   accepted;
      accepted = (alloc_q.size() < DEPTH);
      id = id_of_count(alloc_seq);
      check_value("full", 64'(!accepted), 64'(full));
      check_value("alloc_robid", 64'(id), 64'(alloc_robid));
      alloc_valid  = 1'b1;
      alloc_opcode = op;
      alloc_dest   = dest;
      alloc_pc     = pc;
      if (accepted) begin
         ins.robid  = id;
         ins.opcode = op;
         ins.dest   = dest;
         ins.pc     = pc;
         alloc_q.push_back(ins);
         alloc_seq++;
      end
   endtask

   task automatic drive_random(output rob_defs_pkg::t_rob_id id);
      drive_alloc(instr_pkg::t_opcode'(3'(rand_below(5))), 5'(rand_below(32)),
                  $random(seed), id);
   endtask

   task automatic drive_wb(input rob_defs_pkg::t_rob_id id, input logic mis,
                           input logic [instr_pkg::XLEN-1:0] redir);
      wb_valid          = 1'b1;
      wb_robid          = id;
      wb_mispred        = mis;
      wb_redirect_pc    = redir;
      wb_done[id.idx]   = 1'b1;
      wb_mis[id.idx]    = mis;
      wb_redir[id.idx]  = redir;
   endtask

   task automatic wait_queue_at_most(input int n, input string what);
      int cyc;
      cyc = 0;
      while (alloc_q.size() > n && cyc < TIMEOUT) begin
         tick();
         cyc++;
      end
      if (alloc_q.size() > n) begin
         report_error({"timeout after 200 cycles waiting for ", what});
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (errors == test_errors_base) begin
         $display("test %0d %s: ok", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors_base);
      end
      test_errors_base = errors;
   endtask

   always @(negedge clk) begin : compare
      t_instr  head;
      t_record want;
      if (!reset && (retire_valid || flush_valid)) begin
         if (alloc_q.size() == 0) begin
            report_error("retire or flush with no instruction outstanding");
         end else begin
            head = alloc_q.pop_front();
            want = expected_record(head);
            if (!wb_done[head.robid.idx]) begin
               report_error("instruction left the buffer before its writeback");
            end
            check_value("flush_valid", 64'(want.is_flush), 64'(flush_valid));
            check_value("retire_valid", 64'(!want.is_flush), 64'(retire_valid));
            if (want.is_flush) begin
               check_value("flush_robid", 64'(want.robid), 64'(flush_robid));
               check_value("flush_pc", 64'(want.pc), 64'(flush_pc));
               // Younger ones are gone, pointers restart at zero
               alloc_q.delete();
               alloc_seq = 0;
               clear_wb();
               flush_count++;
            end else begin
               check_value("retire_robid", 64'(want.robid), 64'(retire_robid));
               check_value("retire_opcode", 64'(want.opcode), 64'(retire_opcode));
               check_value("retire_dest", 64'(want.dest), 64'(retire_dest));
               check_value("retire_pc", 64'(want.pc), 64'(retire_pc));
               wb_done[head.robid.idx] = 1'b0;
               retire_count++;
            end
         end
      end
   end

   initial begin : stimulus
      rob_defs_pkg::t_rob_id ids [3*DEPTH];
      rob_defs_pkg::t_rob_id tmp;
      rob_defs_pkg::t_rob_id pend_id [$];
      int                    pend_wait [$];
      int unsigned           j;
      int                    sent;
      int                    cyc;
      int                    retire_base;
      int                    flush_base;
      logic                  wb_sent;

      seed           = 42;
      reset          = 1'b1;
      alloc_valid    = 1'b0;
      alloc_opcode   = instr_pkg::OP_ALU;
      alloc_dest     = '0;
      alloc_pc       = '0;
      wb_valid       = 1'b0;
      wb_robid       = '0;
      wb_mispred     = 1'b0;
      wb_redirect_pc = '0;
      clear_wb();
      repeat (10) @(posedge clk);
      #2;
      reset = 1'b0;

      check_value("retire_valid", 64'(0), 64'(retire_valid));
      check_value("flush_valid", 64'(0), 64'(flush_valid));
      check_value("full", 64'(0), 64'(full));
      check_value("alloc_robid", 64'(0), 64'(alloc_robid));
      end_test("reset values");

      retire_base = retire_count;
      for (int i = 0; i < 6; i++) begin
         drive_random(ids[i]);
         tick();
      end
      // Shuffle the writeback order
      for (int i = 5; i > 0; i--) begin
         j = rand_below(i + 1);
         tmp = ids[i];
         ids[i] = ids[j];
         ids[j] = tmp;
      end
      for (int i = 0; i < 6; i++) begin
         drive_wb(ids[i], 1'b0, '0);
         tick();
      end
      wait_queue_at_most(0, "six instructions to retire");
      check_value("retire_count", 64'(6), 64'(retire_count - retire_base));
      end_test("in-order retire under out-of-order writeback");

      for (int i = 0; i < DEPTH; i++) begin
         drive_random(ids[i]);
         tick();
      end
      check_value("full", 64'(1), 64'(full));
      // Dropped while full, never retires
      drive_alloc(instr_pkg::OP_JUMP, 5'd31, 32'hdead_0000, tmp);
      tick();
      drive_wb(ids[0], 1'b0, '0);
      tick();
      wait_queue_at_most(DEPTH - 1, "the first retire while full");
      check_value("full", 64'(0), 64'(full));
      for (int i = 1; i < DEPTH; i++) begin
         drive_wb(ids[i], 1'b0, '0);
         tick();
      end
      wait_queue_at_most(0, "the full buffer to drain");
      end_test("full");

      retire_base = retire_count;
      flush_base  = flush_count;
      for (int i = 0; i < 5; i++) begin
         drive_random(ids[i]);
         tick();
      end
      drive_wb(ids[3], 1'b0, '0);
      tick();
      drive_wb(ids[2], 1'b1, $random(seed));
      tick();
      drive_wb(ids[4], 1'b0, '0);
      tick();
      drive_wb(ids[0], 1'b0, '0);
      tick();
      drive_wb(ids[1], 1'b0, '0);
      tick();
      wait_queue_at_most(0, "the mispredict flush");
      check_value("retire_count", 64'(2), 64'(retire_count - retire_base));
      check_value("flush_count", 64'(1), 64'(flush_count - flush_base));
      end_test("mispredict flush");

      check_value("alloc_robid", 64'(0), 64'(alloc_robid));
      check_value("full", 64'(0), 64'(full));
      for (int i = 0; i < 4; i++) begin
         drive_random(ids[i]);
         tick();
      end
      for (int i = 3; i >= 0; i--) begin
         drive_wb(ids[i], 1'b0, '0);
         tick();
      end
      wait_queue_at_most(0, "the stream after flush");
      end_test("state after flush");

      retire_base = retire_count;
      sent = 0;
      cyc  = 0;
      while ((sent < 3*DEPTH || pend_id.size() != 0) && cyc < TIMEOUT) begin
         for (int k = 0; k < pend_wait.size(); k++) begin
            pend_wait[k]--;
         end
         // Oldest expired delay goes first
         wb_sent = 1'b0;
         for (int k = 0; k < pend_id.size(); k++) begin
            if (!wb_sent && pend_wait[k] <= 0) begin
               drive_wb(pend_id[k], 1'b0, '0);
               pend_id.delete(k);
               pend_wait.delete(k);
               wb_sent = 1'b1;
            end
         end
         if (sent < 3*DEPTH && alloc_q.size() < DEPTH) begin
            drive_random(tmp);
            pend_id.push_back(tmp);
            pend_wait.push_back(int'(rand_below(4)));
            sent++;
         end
         tick();
         cyc++;
      end
      if (cyc >= TIMEOUT) begin
         report_error("timeout after 200 cycles feeding the wrap stream");
      end
      wait_queue_at_most(0, "the wrap stream to retire");
      check_value("retire_count", 64'(3*DEPTH), 64'(retire_count - retire_base));
      check_value("alloc_robid", 64'(id_of_count(4 + 3*DEPTH)), 64'(alloc_robid));
      end_test("pointer wrap");

      $display("%0d tests run, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
